// ==== csr_wb_slave.sv ====
module csr_wb_slave import trig_pkg::*; (
	input  logic     CLK125,
	input  logic     rst_n_i,
	input  wb_req_t  wb_req_i,
	output wb_rsp_t  wb_rsp_o,
	input  tok_evt_t evt_i,
	output logic     enable_o,
	output logic     access_o
);

	// Unused STATUS bits between err flag and count
	localparam int STAT_PAD_W = WB_DAT_W - TOK_CNT_W - 1 - TOKEN_W;

	logic                 ack_q;
	logic [WB_DAT_W-1:0]  rdat_q;
	logic [WB_DAT_W-1:0]  rdat;
	logic [WB_DAT_W-1:0]  status_word;
	logic                 enable_q;
	logic [TOKEN_W-1:0]   last_tok_q;
	logic                 last_err_q;
	logic [TOK_CNT_W-1:0] tok_cnt_q;
	logic                 req;
	logic                 wr_ctrl;
	logic                 wr_status;
	csr_addr_e            addr;

	////////////////////
	// Bus decode
	////////////////////

	// New request, never on the cycle right after our own ack
	assign req  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	assign addr = csr_addr_e'(wb_req_i.adr);

	assign wr_ctrl   = req & wb_req_i.we & (addr == CSR_CTRL);
	assign wr_status = req & wb_req_i.we & (addr == CSR_STATUS);

	assign status_word = {tok_cnt_q, {STAT_PAD_W{1'b0}}, last_err_q, last_tok_q};

	// Read mux
	always_comb begin
		case (addr)
			CSR_CTRL:    rdat = {{(WB_DAT_W-1){1'b0}}, enable_q};
			CSR_STATUS:  rdat = status_word;
			CSR_VERSION: rdat = FW_VERSION;
			default:     rdat = '0;
		endcase
	end

	////////////////////
	// Handshake
	////////////////////

	// Ack one edge after the request is first seen
	always_ff @(posedge CLK125) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	// Read data goes out with the ack
	always_ff @(posedge CLK125) begin
		if (req)
			rdat_q <= rdat;
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = rdat_q;
	// One pulse per access, for the LED
	assign access_o     = ack_q;

	////////////////////
	// Registers
	////////////////////

	// CTRL bit 0 gates token capture
	always_ff @(posedge CLK125) begin
		if (!rst_n_i)
			enable_q <= 1'b0;
		else if (wr_ctrl)
			enable_q <= wb_req_i.dat[0];
	end

	assign enable_o = enable_q;

	// Status follows each event, same edge as the link word
	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			last_tok_q <= '0;
			last_err_q <= 1'b0;
			tok_cnt_q  <= '0;
		end else begin
			if (evt_i.valid) begin
				last_tok_q <= evt_i.token;
				last_err_q <= evt_i.err;
			end
			// Write clears, an event on the same edge still counts
			tok_cnt_q <= (wr_status ? '0 : tok_cnt_q) + TOK_CNT_W'(evt_i.valid);
		end
	end

endmodule

// ==== filelist.f ====
trig_pkg.sv
trig_frame_rx.sv
tok_link_fmt.sv
csr_wb_slave.sv
led_stretch.sv
trig_top.sv
tb_trig_top.sv

// ==== led_stretch.sv ====
module led_stretch import trig_pkg::*; #(
	parameter int unsigned LED_STRETCH = 12_500_000
) (
	input  logic                CLK125,
	input  logic                rst_n_i,
	input  led_req_t            req_i,
	output logic [NUM_LEDS-1:0] led_o
);

	localparam int CNT_W = $clog2(LED_STRETCH + 1);

	// One down-counter per LED
	logic [CNT_W-1:0] cnt_q [NUM_LEDS];

	////////////////////
	// Stretchers
	////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_LEDS; i++)
				cnt_q[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_LEDS; i++) begin
				// Retrigger restarts the full hold time
				if (req_i[i])
					cnt_q[i] <= CNT_W'(LED_STRETCH);
				else if (cnt_q[i] != '0)
					cnt_q[i] <= cnt_q[i] - 1'b1;
			end
		end
	end

	// Lit while counting
	always_comb begin
		for (int i = 0; i < NUM_LEDS; i++)
			led_o[i] = (cnt_q[i] != '0);
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_trig_top -f filelist.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	exit 1
fi
exit 0

// ==== tb_trig_top.sv ====
module tb_trig_top import trig_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYC = 4000;

	// One expected token word and the cycle it is due
	typedef struct packed {
		logic [31:0] due;
		link_word_t  word;
	} exp_t;

	logic          CLK125;
	logic          rst_n_i;
	logic          ser_trig_i;
	logic          inh_i;
	wb_req_t       wb_req;
	wb_rsp_t       wb_rsp;
	link_word_t    link_o;
	logic [NUM_LEDS-1:0] led_o;

	int            cycles = 0;
	int            errors = 0;
	logic [31:0]   lfsr_q = 32'd74809;
	exp_t          exp_q [$];
	logic [31:0]   last_due;
	// Reference copy of the register block state
	logic          en_model = 1'b0;
	logic [15:0]   cnt_model = '0;
	logic          err_model = 1'b0;
	logic [9:0]    tok_model = '0;

	trig_top #(
		.LED_STRETCH (20)
	) i_dut (
		.CLK125     (CLK125),
		.rst_n_i    (rst_n_i),
		.ser_trig_i (ser_trig_i),
		.inh_i      (inh_i),
		.wb_req_i   (wb_req),
		.wb_rsp_o   (wb_rsp),
		.link_o     (link_o),
		.led_o      (led_o)
	);

	initial begin
		CLK125 = 1'b0;
		forever #2 CLK125 = ~CLK125;
	end

	always @(posedge CLK125)
		cycles <= cycles + 1;

	////////////////////
	// Reference model
	////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val    = {val[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
		end
		return val;
	endfunction

	function automatic link_word_t comma_ref();
		return '{is_k: 1'b1, data: COMMA_WORD};
	endfunction

	// Tag, err bit, then token, sent as data
	function automatic link_word_t link_ref(input logic [9:0] tok, input logic err);
		return '{is_k: 1'b0, data: {LINK_TOK_TAG, err, tok}};
	endfunction

	// Count on top, err at bit 10, token at the bottom
	function automatic logic [31:0] status_ref();
		return {cnt_model, 5'b00000, err_model, tok_model};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] gotv);
		$display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expv, gotv);
		errors++;
	endtask

	////////////////////
	// Bus and line drivers
	////////////////////

	// One Wishbone cycle, ack expected one cycle after the request
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge CLK125);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		do begin
			@(negedge CLK125);
			waited++;
		end while (!wb_rsp.ack && waited < 8);
		assert (waited == 1 && wb_rsp.ack)
		else report_mismatch("wb ack latency", 32'd1, waited);
		rdat   = wb_rsp.dat;
		wb_req = '0;
		@(negedge CLK125);
		// Single-cycle ack
		assert (!wb_rsp.ack) else report_mismatch("wb_rsp_o.ack", 32'd0, 32'(wb_rsp.ack));
	endtask

	// Start bit, token MSB first, even parity, then idle
	task automatic send_frame(input logic [9:0] tok, input logic flip);
		logic [11:0] bits;
		logic        accept;
		exp_t        entry;
		bits   = {1'b1, tok, (^tok) ^ flip};
		accept = en_model && !inh_i;
		for (int i = 11; i >= 0; i--) begin
			@(negedge CLK125);
			ser_trig_i = bits[i];
			if (i == 11 && accept) begin
				// Start bit sampled next edge, word out after edge 13
				entry.due  = cycles + 14;
				entry.word = link_ref(tok, flip);
				last_due   = entry.due;
				exp_q.push_back(entry);
				cnt_model++;
				tok_model  = tok;
				err_model  = flip;
			end
		end
		@(negedge CLK125);
		ser_trig_i = 1'b0;
	endtask

	task automatic drain_expected();
		while (exp_q.size() != 0)
			@(negedge CLK125);
		@(negedge CLK125);
	endtask

	task automatic check_status();
		logic [31:0] rd;
		wb_access(1'b0, CSR_STATUS, '0, rd);
		assert (rd == status_ref()) else report_mismatch("STATUS", status_ref(), rd);
	endtask

	////////////////////
	// Link word checker
	////////////////////

	initial begin
		exp_t head;
		@(posedge rst_n_i);
		forever begin
			@(negedge CLK125);
			if (exp_q.size() != 0 && exp_q[0].due == cycles) begin
				head = exp_q.pop_front();
				assert (link_o == head.word)
				else report_mismatch("link_o", 32'(head.word), 32'(link_o));
			end else begin
				// Comma at all other times
				assert (link_o == comma_ref())
				else report_mismatch("link_o", 32'(comma_ref()), 32'(link_o));
			end
		end
	end

	initial begin
		wait (cycles == TIMEOUT_CYC);
		$display("Timeout: tests did not complete within %0d cycles, %0d errors counted",
			TIMEOUT_CYC, errors);
		$display("Something failed");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		logic [31:0] rd;
		logic [9:0]  tok;
		int          waited;
		rst_n_i    = 1'b0;
		ser_trig_i = 1'b0;
		inh_i      = 1'b0;
		wb_req     = '0;
		repeat (16) @(negedge CLK125);
		rst_n_i = 1'b1;
		@(negedge CLK125);

		// Only LED 3 lit after reset, capture still disabled
		assert (led_o == 4'b1000) else report_mismatch("led_o", 32'h8, 32'(led_o));
		send_frame(10'h2A5, 1'b0);
		drain_expected();
		check_status();

		// Enable capture, random good frames
		wb_access(1'b1, CSR_CTRL, 32'h1, rd);
		en_model = 1'b1;
		wb_access(1'b0, CSR_CTRL, '0, rd);
		assert (rd == 32'h1) else report_mismatch("CTRL", 32'h1, rd);
		repeat (30) begin
			tok = 10'(rand_bits(10));
			send_frame(tok, 1'b0);
		end
		drain_expected();
		check_status();

		// Parity errors, last one always flipped
		for (int i = 0; i < 6; i++) begin
			tok = 10'(rand_bits(10));
			rd  = rand_bits(1);
			send_frame(tok, (i == 5) ? 1'b1 : rd[0]);
		end
		while (cycles < last_due)
			@(negedge CLK125);
		// Token received LED follows the event
		assert (led_o[2]) else report_mismatch("led_o[2]", 32'd1, 32'(led_o[2]));
		waited = 0;
		while (led_o[0] && waited < 40) begin
			waited++;
			@(negedge CLK125);
		end
		assert (waited == 20) else report_mismatch("led_o[0] lit cycles", 32'd20, waited);
		drain_expected();
		check_status();

		// Inhibit, LED 3 drops and frames are ignored
		@(negedge CLK125);
		inh_i  = 1'b1;
		waited = 0;
		while (led_o[3] && waited < 40) begin
			@(negedge CLK125);
			waited++;
		end
		assert (waited <= 21) else report_mismatch("led_o[3] off cycles", 32'd21, waited);
		repeat (3) begin
			tok = 10'(rand_bits(10));
			send_frame(tok, 1'b0);
		end
		drain_expected();
		check_status();
		@(negedge CLK125);
		inh_i = 1'b0;

		// Version, unused address, access LED, count clear
		wb_access(1'b0, CSR_VERSION, '0, rd);
		assert (rd == FW_VERSION) else report_mismatch("VERSION", FW_VERSION, rd);
		wb_access(1'b0, 2'd3, '0, rd);
		assert (rd == 32'h0) else report_mismatch("address 3", 32'h0, rd);
		assert (led_o[1]) else report_mismatch("led_o[1]", 32'd1, 32'(led_o[1]));
		wb_access(1'b1, CSR_STATUS, 32'hFFFF_FFFF, rd);
		cnt_model = '0;
		check_status();

		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== tok_link_fmt.sv ====
module tok_link_fmt import trig_pkg::*; (
	input  logic       CLK125,
	input  logic       rst_n_i,
	input  tok_evt_t   evt_i,
	output link_word_t link_o
);

	link_word_t next_word;

	////////////////////
	// Word select
	////////////////////

	always_comb begin
		if (evt_i.valid) begin
			// Token word, plain data
			next_word.is_k = 1'b0;
			next_word.data = {LINK_TOK_TAG, evt_i.err, evt_i.token};
		end else begin
			// Idle comma
			next_word.is_k = 1'b1;
			next_word.data = COMMA_WORD;
		end
	end

	////////////////////
	// Output register
	////////////////////

	// Token word lasts exactly one cycle
	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			link_o.is_k <= 1'b1;
			link_o.data <= COMMA_WORD;
		end else begin
			link_o <= next_word;
		end
	end

endmodule

// ==== trig_frame_rx.sv ====
module trig_frame_rx import trig_pkg::*; (
	input  logic     CLK125,
	input  logic     rst_n_i,
	input  logic     ser_trig_i,
	input  logic     enable_i,
	input  logic     inh_i,
	output tok_evt_t evt_o
);

	localparam int BIT_CNT_W = $clog2(TOKEN_W);

	rx_state_e          state_q;
	logic [BIT_CNT_W-1:0] bit_cnt_q;
	logic [TOKEN_W-1:0] shift_q;
	// Frame done at the parity edge, presented one edge later
	tok_evt_t           pend_q;
	logic               par_err;

	// Even parity over token plus parity bit must come out zero
	assign par_err = (^shift_q) ^ ser_trig_i;

	////////////////////
	// Frame FSM
	////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			state_q   <= RX_IDLE;
			bit_cnt_q <= '0;
			pend_q    <= '0;
		end else begin
			// Single-cycle pending flag by default
			pend_q.valid <= 1'b0;
			case (state_q)
				RX_IDLE: begin
					// Start bit counts only when capture is allowed
					if (ser_trig_i && enable_i && !inh_i) begin
						state_q   <= RX_DATA;
						bit_cnt_q <= '0;
					end
				end
				RX_DATA: begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					// Last token bit taken
					if (bit_cnt_q == BIT_CNT_W'(TOKEN_W - 1))
						state_q <= RX_PARITY;
				end
				RX_PARITY: begin
					// Inhibit no longer matters here, frame completes
					pend_q.valid <= 1'b1;
					pend_q.err   <= par_err;
					pend_q.token <= shift_q;
					state_q      <= RX_IDLE;
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// Token bits, MSB first
	always_ff @(posedge CLK125) begin
		if (state_q == RX_DATA)
			shift_q <= {shift_q[TOKEN_W-2:0], ser_trig_i};
	end

	////////////////////
	// Event output
	////////////////////

	// Valid in the cycle after the edge following the parity bit
	always_ff @(posedge CLK125) begin
		if (!rst_n_i)
			evt_o <= '0;
		else
			evt_o <= pend_q;
	end

endmodule

// ==== trig_pkg.sv ====
package trig_pkg;

	////////////////////
	// Widths
	////////////////////

	// Trigger token carried in one frame
	localparam int TOKEN_W = 10;
	// Front-panel LEDs
	localparam int NUM_LEDS = 4;
	// Word sent to the channel links
	localparam int LINK_W = 16;
	// Wishbone data and word address
	localparam int WB_DAT_W = 32;
	localparam int WB_ADR_W = 2;
	// Running token count in STATUS
	localparam int TOK_CNT_W = 16;

	////////////////////
	// Constants
	////////////////////

	// Idle comma, goes out as a K-character
	localparam logic [LINK_W-1:0] COMMA_WORD = 16'h00BC;
	// Top five bits of a token word
	localparam logic [4:0] LINK_TOK_TAG = 5'b10000;
	// Returned by the VERSION register
	localparam logic [WB_DAT_W-1:0] FW_VERSION = 32'h5446_0102;

	////////////////////
	// Enums
	////////////////////

	// Register word addresses, address 3 reads as zero
	typedef enum logic [WB_ADR_W-1:0] {
		CSR_CTRL    = 2'd0,
		CSR_STATUS  = 2'd1,
		CSR_VERSION = 2'd2
	} csr_addr_e;

	// Frame receiver states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY
	} rx_state_e;

	////////////////////
	// Structs
	////////////////////

	// One decoded frame, valid for a single cycle
	typedef struct packed {
		logic               valid;
		logic               err;
		logic [TOKEN_W-1:0] token;
	} tok_evt_t;

	// Link word with its K-character flag
	typedef struct packed {
		logic              is_k;
		logic [LINK_W-1:0] data;
	} link_word_t;

	// Wishbone master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
	} wb_req_t;

	// Wishbone slave to master
	typedef struct packed {
		logic                ack;
		logic [WB_DAT_W-1:0] dat;
	} wb_rsp_t;

	// One trigger request per LED
	typedef logic [NUM_LEDS-1:0] led_req_t;

endpackage

// ==== trig_top.sv ====
module trig_top import trig_pkg::*; #(
	parameter int unsigned LED_STRETCH = 12_500_000
) (
	input  logic                CLK125,
	input  logic                rst_n_i,
	input  logic                ser_trig_i,
	input  logic                inh_i,
	input  wb_req_t             wb_req_i,
	output wb_rsp_t             wb_rsp_o,
	output link_word_t          link_o,
	output logic [NUM_LEDS-1:0] led_o
);

	tok_evt_t evt;
	logic     enable;
	logic     access;
	led_req_t led_req;

	////////////////////
	// Token path
	////////////////////

	// Serial frame decode
	trig_frame_rx i_rx (
		.CLK125     (CLK125),
		.rst_n_i    (rst_n_i),
		.ser_trig_i (ser_trig_i),
		.enable_i   (enable),
		.inh_i      (inh_i),
		.evt_o      (evt)
	);

	// Token word or comma to the links
	tok_link_fmt i_fmt (
		.CLK125  (CLK125),
		.rst_n_i (rst_n_i),
		.evt_i   (evt),
		.link_o  (link_o)
	);

	////////////////////
	// Slow control
	////////////////////

	csr_wb_slave i_csr (
		.CLK125   (CLK125),
		.rst_n_i  (rst_n_i),
		.wb_req_i (wb_req_i),
		.wb_rsp_o (wb_rsp_o),
		.evt_i    (evt),
		.enable_o (enable),
		.access_o (access)
	);

	////////////////////
	// LEDs
	////////////////////

	// Token error
	assign led_req[0] = evt.valid & evt.err;
	// Register access
	assign led_req[1] = access;
	// Token received
	assign led_req[2] = evt.valid;
	// No inhibit
	assign led_req[3] = ~inh_i;

	led_stretch #(
		.LED_STRETCH (LED_STRETCH)
	) i_led (
		.CLK125  (CLK125),
		.rst_n_i (rst_n_i),
		.req_i   (led_req),
		.led_o   (led_o)
	);

endmodule
